// File: conv_accel.f
source/conv_pkg.sv
source/conv_cfg_if.sv
source/conv_config_loader.sv
source/conv_col_counter.sv
source/conv_window_mac.sv
source/conv_controller.sv
source/conv_top.sv
verif/conv_tb.sv

// File: verif/conv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module conv_tb;
	import conv_pkg::*;

	localparam addr_t cfg_base = 32'h1000_0000;
	localparam int buf_width = 64;
	localparam int col_w = $clog2(buf_width);
	localparam int runs = 3;
	localparam int max_bands = 6; // height 8
	localparam int cycle_limit = runs * (40 + max_bands * (buf_width + 20));

	logic clk = 1'b0;
	logic rst_n;
	addr_t data_mem;
	logic mapped_data_valid;
	logic making_request;
	column_t rd_column;
	addr_t address_mem, read_address, write_address;
	logic request_read, request_write, col_read, wr_en, done;
	dim_t write_request_width;
	logic [col_w-1:0] read_col_address, write_col_address;
	pixel_t wr_pixel;

	logic [31:0] rng = 32'd76;
	dim_t width, height;
	addr_t src_base, dst_base;
	coef_t taps [9];
	logic [23:0] taps_pad; // unused upper bytes of the last taps word
	pixel_t img [8][64];
	column_t rbuf [64];
	addr_t start_word = '0;
	addr_t prev_addr = '0;
	logic pend_read = 1'b0;
	int pend_col = 0;
	logic req_pending = 1'b0;
	logic run_active = 1'b0;
	int busy_left = 0;
	int reads = 0, writes = 0, band_writes = 0, band_cols = 0, runs_done = 0;
	int errors = 0, checks = 0, cycles = 0;

	conv_top #(.cfg_base(cfg_base), .buf_width(buf_width)) DUT (.*);

	always #4 clk = ~clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int unsigned pick(input int unsigned lo, input int unsigned hi);
		rng = xorshift32(rng);
		return lo + rng % (hi - lo + 1);
	endfunction

	function automatic addr_t mem_word(input addr_t a);
		addr_t ofs;
		ofs = a - cfg_base;
		case (ofs)
			32'h000: return {height, width};
			32'h004: return src_base;
			32'h008: return dst_base;
			32'h00c: return {taps[3], taps[2], taps[1], taps[0]};
			32'h010: return {taps[7], taps[6], taps[5], taps[4]};
			32'h014: return {taps_pad, taps[8]};
			32'h120: return start_word;
			default: return a ^ {a[15:0], a[31:16]} ^ 32'h6c3e_91d5;
		endcase
	endfunction

	// clipped 3x3 sum for one output pixel of a band
	function automatic pixel_t ref_pixel(input int band, input int col);
		int sum;
		sum = 0;
		for (int r = 0; r < 3; r++)
			for (int c = 0; c < 3; c++)
				sum += int'(taps[3*r + c]) * int'(img[band + r][col + c]);
		if (sum < 0)
			return 8'd0;
		else if (sum > 255)
			return 8'd255;
		return pixel_t'(sum);
	endfunction

	task automatic flag_error(input string msg);
		errors++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_dim(input string name, input dim_t got, input dim_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic setup_run(input int run);
		width = dim_t'(pick(4, buf_width));
		height = dim_t'(pick(3, 8));
		src_base = addr_t'(pick(0, 32'hffff_fffe));
		dst_base = addr_t'(pick(0, 32'hffff_fffe));
		taps_pad = 24'(pick(0, 32'hff_ffff));
		for (int i = 0; i < 9; i++) begin
			if (run % 2 == 1)
				taps[i] = coef_t'(pick(0, 255));
			else
				taps[i] = coef_t'(int'(pick(0, 3)) - 1); // small taps leave more sums unclipped
		end
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < 64; c++)
				img[r][c] = pixel_t'(pick(0, 255));
	endtask

	task automatic load_band(input int band);
		for (int c = 0; c < 64; c++)
			rbuf[c] = {img[band + 2][c], img[band + 1][c], img[band][c]};
	endtask

	// monitors and external models on the falling edge
	always @(negedge clk) begin
		if (!run_active)
			check_addr("address_mem", address_mem, cfg_base + 32'h120);
		if (!run_active && (request_read || request_write || col_read || wr_en || done))
			flag_error("DUT activity outside a started run");
		if (request_read) begin
			if (reads != writes || reads >= height - 2)
				flag_error("read request out of band order");
			check_addr("read_address", read_address, src_base + addr_t'(reads) * addr_t'(width));
			load_band(reads);
			reads++;
			band_cols = 0;
		end
		if (col_read) begin
			check_dim("read_col_address", dim_t'(read_col_address), dim_t'(band_cols));
			band_cols++;
		end
		if (wr_en) begin
			if (band_writes >= width - 2)
				flag_error("more than W-2 results in one band");
			check_dim("write_col_address", dim_t'(write_col_address), dim_t'(band_writes));
			check_pixel("wr_pixel", wr_pixel, ref_pixel(reads - 1, band_writes));
			band_writes++;
		end
		if (request_write) begin
			if (writes + 1 != reads)
				flag_error("write request without a fetched band");
			if (band_writes != width - 2)
				flag_error("write request after the wrong number of results");
			if (band_cols != width)
				flag_error("write request after the wrong number of column reads");
			check_addr("write_address", write_address,
				dst_base + addr_t'(writes) * addr_t'(width - 16'd2));
			check_dim("write_request_width", write_request_width, width - 16'd2);
			band_writes = 0;
			writes++;
		end
		if (done) begin
			if (reads != height - 2 || writes != height - 2)
				flag_error("done before every band was stored");
			runs_done++;
			run_active = 1'b0;
		end
		if (busy_left > 0) begin
			busy_left--;
			if (busy_left == 0)
				making_request = 1'b0; // transfer complete
		end
		if (req_pending) begin
			making_request = 1'b1;
			busy_left = pick(1, 6);
			req_pending = 1'b0;
		end
		if (request_read || request_write)
			req_pending = 1'b1;
		mapped_data_valid = (pick(0, 3) != 0);
		data_mem = mem_word(prev_addr); // one cycle behind the address
		if (mapped_data_valid && prev_addr == cfg_base + 32'h120 && start_word == 32'd1) begin
			start_word = '0; // start word reads back clear
			run_active = 1'b1;
			reads = 0;
			writes = 0;
			band_writes = 0;
		end
		prev_addr = address_mem;
		if (pend_read)
			rd_column = rbuf[pend_col];
		pend_read = col_read;
		pend_col = int'(read_col_address);
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: runs not finished after %0d cycles", cycle_limit);
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial begin
		rst_n = 1'b0;
		data_mem = '0;
		mapped_data_valid = 1'b0;
		making_request = 1'b0;
		rd_column = '0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		for (int run = 0; run < runs; run++) begin
			@(posedge clk);
			setup_run(run);
			repeat (4) begin
				@(posedge clk);
				start_word = addr_t'(pick(2, 32'hffff)); // must not start a run
			end
			repeat (2) @(posedge clk);
			start_word = 32'd1;
			wait (runs_done == run + 1);
		end
		repeat (12) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: source/conv_top.sv
`timescale 1ns/100ps
`default_nettype none

module conv_top #(
	parameter conv_pkg::addr_t cfg_base = 32'h1000_0000,
	parameter int buf_width = 64
) (
	input wire clk,
	input wire rst_n,
	input wire conv_pkg::addr_t data_mem,
	input wire mapped_data_valid,
	input wire making_request,
	input wire conv_pkg::column_t rd_column,
	output conv_pkg::addr_t address_mem,
	output logic request_read,
	output conv_pkg::addr_t read_address,
	output logic request_write,
	output conv_pkg::addr_t write_address,
	output conv_pkg::dim_t write_request_width,
	output logic [$clog2(buf_width)-1:0] read_col_address,
	output logic col_read,
	output logic [$clog2(buf_width)-1:0] write_col_address,
	output logic wr_en,
	output conv_pkg::pixel_t wr_pixel,
	output logic done
);
	import conv_pkg::*;

	addr_t loader_addr;
	addr_t ctrl_addr;
	logic loading;
	logic read_inc, read_clr, write_clr, band_clr;

	conv_cfg_if cfg_bus ();

	assign address_mem = loading ? loader_addr : ctrl_addr; // loader owns the port while loading

	conv_config_loader #(.cfg_base(cfg_base)) u_loader (
		.clk, .rst_n, .data_mem, .mapped_data_valid,
		.address_mem(loader_addr),
		.cfg(cfg_bus.loader)
	);

	conv_controller #(.cfg_base(cfg_base), .buf_width(buf_width)) u_ctrl (
		.clk, .rst_n, .data_mem, .mapped_data_valid, .making_request,
		.cfg(cfg_bus.controller),
		.read_col_address, .write_col_address,
		.address_mem_ctrl(ctrl_addr), .loading,
		.request_read, .read_address, .request_write, .write_address, .write_request_width,
		.col_read, .read_inc, .read_clr, .write_clr, .band_clr, .done
	);

	conv_col_counter #(.buf_width(buf_width)) u_cols (
		.clk, .rst_n, .read_inc, .read_clr,
		.write_inc(wr_en), .write_clr,
		.read_col_address, .write_col_address
	);

	conv_window_mac u_mac (
		.clk, .rst_n, .col_read, .band_clr, .rd_column,
		.cfg(cfg_bus.datapath),
		.result_valid(wr_en), .wr_pixel
	);

endmodule

`default_nettype wire

// File: source/conv_controller.sv
`timescale 1ns/100ps
`default_nettype none

module conv_controller #(
	parameter conv_pkg::addr_t cfg_base = 32'h1000_0000,
	parameter int buf_width = 64
) (
	input wire clk,
	input wire rst_n,
	input wire conv_pkg::addr_t data_mem,
	input wire mapped_data_valid,
	input wire making_request,
	conv_cfg_if.controller cfg,
	input wire [$clog2(buf_width)-1:0] read_col_address,
	input wire [$clog2(buf_width)-1:0] write_col_address,
	output conv_pkg::addr_t address_mem_ctrl,
	output logic loading,
	output logic request_read,
	output conv_pkg::addr_t read_address,
	output logic request_write,
	output conv_pkg::addr_t write_address,
	output conv_pkg::dim_t write_request_width,
	output logic col_read,
	output logic read_inc,
	output logic read_clr,
	output logic write_clr,
	output logic band_clr,
	output logic done
);
	import conv_pkg::*;

	ctrl_state_e state, next;
	dim_t bands_left;
	dim_t last_col;
	logic band_start; // clears counters and window for a new band

	assign last_col = cfg.image_width - 16'd1;
	assign write_request_width = cfg.image_width - 16'd2; // results per band
	assign address_mem_ctrl = cfg_base + cfg_ofs_start;
	assign loading = (state == LOAD_CONFIG);

	assign read_inc = col_read;
	assign read_clr = band_start;
	assign write_clr = band_start;
	assign band_clr = band_start;

	always_comb begin
		next = state;
		case (state)
			IDLE: if (mapped_data_valid && data_mem == 32'd1) next = LOAD_CONFIG;
			LOAD_CONFIG: if (cfg.load_done) next = FETCH;
			FETCH: next = FETCH_SETTLE;
			FETCH_SETTLE: next = FETCH_WAIT; // transfer busy now visible
			FETCH_WAIT: if (!making_request) next = PRIME;
			PRIME: if (read_col_address == 1'b1) next = OPERATE;
			OPERATE: if (dim_t'(read_col_address) == last_col) next = DRAIN;
			DRAIN: if (dim_t'(write_col_address) == write_request_width) next = STORE;
			STORE: next = STORE_SETTLE;
			STORE_SETTLE: next = STORE_WAIT;
			STORE_WAIT: if (!making_request) next = NEXT_BAND;
			NEXT_BAND: next = (bands_left == 16'd1) ? DONE : FETCH;
			DONE: next = IDLE;
			default: next = IDLE;
		endcase
	end

	// strobes are registered from the next state
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			cfg.load_start <= 1'b0;
			request_read <= 1'b0;
			request_write <= 1'b0;
			col_read <= 1'b0;
			band_start <= 1'b0;
			done <= 1'b0;
		end else begin
			state <= next;
			cfg.load_start <= (state == IDLE) && (next == LOAD_CONFIG);
			request_read <= (next == FETCH);
			request_write <= (next == STORE);
			col_read <= (next == PRIME) || (next == OPERATE);
			band_start <= (next == FETCH);
			done <= (next == DONE);
		end
	end

	// band base addresses and bands still to go
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			read_address <= '0;
			write_address <= '0;
			bands_left <= '0;
		end else if (state == LOAD_CONFIG && cfg.load_done) begin
			read_address <= cfg.src_address;
			write_address <= cfg.dst_address;
			bands_left <= cfg.image_height - 16'd2;
		end else if (state == NEXT_BAND) begin
			read_address <= read_address + addr_t'(cfg.image_width);
			write_address <= write_address + addr_t'(write_request_width);
			bands_left <= bands_left - 16'd1;
		end
	end

	a_col_read_in_stream: assert property (@(posedge clk) disable iff (!rst_n)
		col_read |-> (state inside {PRIME, OPERATE}) &&
			(dim_t'(read_col_address) <= last_col));

	a_no_request_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(request_read || request_write) |-> !making_request);

endmodule

`default_nettype wire

// File: source/conv_window_mac.sv
`timescale 1ns/100ps
`default_nettype none

module conv_window_mac (
	input wire clk,
	input wire rst_n,
	input wire col_read,
	input wire band_clr,
	input wire conv_pkg::column_t rd_column,
	conv_cfg_if.datapath cfg,
	output logic result_valid,
	output conv_pkg::pixel_t wr_pixel
);
	import conv_pkg::*;

	logic col_shift; // buffer data lines up here
	logic [1:0] shift_cnt; // saturates at 2
	logic win_full;
	column_t win [3]; // 0 is the leftmost column
	column_t next_win [3];
	logic signed [20:0] acc;

	assign next_win[0] = win[1];
	assign next_win[1] = win[2];
	assign next_win[2] = rd_column;

	// third shift or later fills the window
	assign win_full = col_shift && (shift_cnt == 2'd2);

	always_comb begin
		acc = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				acc = acc + $signed(cfg.taps[3*r + c]) * $signed({1'b0, next_win[c][r]});
			end
		end
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			col_shift <= 1'b0;
			shift_cnt <= '0;
			result_valid <= 1'b0;
		end else begin
			col_shift <= col_read;
			result_valid <= win_full;
			if (band_clr)
				shift_cnt <= '0;
			else if (col_shift && shift_cnt != 2'd2)
				shift_cnt <= shift_cnt + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (col_shift) begin
			for (int c = 0; c < 3; c++) win[c] <= next_win[c];
		end
		if (win_full) begin
			if (acc < 0)
				wr_pixel <= 8'd0; // rectify
			else if (acc > 21'sd255)
				wr_pixel <= 8'd255; // saturate
			else
				wr_pixel <= acc[7:0];
		end
	end

endmodule

`default_nettype wire

// File: source/conv_col_counter.sv
`timescale 1ns/100ps
`default_nettype none

module conv_col_counter #(
	parameter int buf_width = 64
) (
	input wire clk,
	input wire rst_n,
	input wire read_inc,
	input wire read_clr,
	input wire write_inc,
	input wire write_clr,
	output logic [$clog2(buf_width)-1:0] read_col_address,
	output logic [$clog2(buf_width)-1:0] write_col_address
);
	localparam int col_w = $clog2(buf_width);

	logic [1:0] inc;
	logic [1:0] clr;
	logic [col_w-1:0] count [2]; // 0 read side, 1 write side

	assign inc = {write_inc, read_inc};
	assign clr = {write_clr, read_clr};

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2; i++) count[i] <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (clr[i])
					count[i] <= '0; // clear wins over step
				else if (inc[i])
					count[i] <= count[i] + 1'b1;
			end
		end
	end

	assign read_col_address = count[0];
	assign write_col_address = count[1];

endmodule

`default_nettype wire

// File: source/conv_config_loader.sv
`timescale 1ns/100ps
`default_nettype none

module conv_config_loader #(
	parameter conv_pkg::addr_t cfg_base = 32'h1000_0000
) (
	input wire clk,
	input wire rst_n,
	input wire conv_pkg::addr_t data_mem,
	input wire mapped_data_valid,
	output conv_pkg::addr_t address_mem,
	conv_cfg_if.loader cfg
);
	import conv_pkg::*;

	cfg_field_e field; // F_END when no walk is running
	logic word_wait; // address out, word not yet taken
	logic take;
	addr_t offset;

	assign take = word_wait && mapped_data_valid;

	always_comb begin
		case (field)
			F_DIMS: offset = cfg_ofs_dims;
			F_SRC: offset = cfg_ofs_src;
			F_DST: offset = cfg_ofs_dst;
			F_TAPS0: offset = cfg_ofs_taps0;
			F_TAPS1: offset = cfg_ofs_taps1;
			F_TAPS2: offset = cfg_ofs_taps2;
			default: offset = '0;
		endcase
	end

	assign address_mem = cfg_base + offset;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			field <= F_END;
			word_wait <= 1'b0;
			cfg.load_done <= 1'b0;
		end else begin
			cfg.load_done <= 1'b0;
			if (cfg.load_start) begin
				field <= F_DIMS;
				word_wait <= 1'b0;
			end else if (field != F_END) begin
				if (!word_wait) begin
					word_wait <= 1'b1; // issue cycle
				end else if (take) begin
					word_wait <= 1'b0;
					field <= cfg_field_e'(field + 3'd1);
					cfg.load_done <= (field == F_TAPS2);
				end
			end
		end
	end

	// unpack each word as it arrives
	always_ff @(posedge clk) begin
		if (take) begin
			case (field)
				F_DIMS: begin
					cfg.image_width <= data_mem[15:0];
					cfg.image_height <= data_mem[31:16];
				end
				F_SRC: cfg.src_address <= data_mem;
				F_DST: cfg.dst_address <= data_mem;
				F_TAPS0: for (int i = 0; i < 4; i++) cfg.taps[i] <= data_mem[8*i +: 8];
				F_TAPS1: for (int i = 0; i < 4; i++) cfg.taps[4+i] <= data_mem[8*i +: 8];
				F_TAPS2: cfg.taps[8] <= data_mem[7:0]; // upper bytes unused
				default: ;
			endcase
		end
	end

	a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		cfg.load_start |-> field == F_END);

endmodule

`default_nettype wire

// File: source/conv_cfg_if.sv
`timescale 1ns/100ps
`default_nettype none

interface conv_cfg_if;
	import conv_pkg::*;

	dim_t image_width;
	dim_t image_height;
	addr_t src_address;
	addr_t dst_address;
	coef_t [8:0] taps; // row-major, tap 0 top left
	logic load_start;
	logic load_done;

	modport loader (input load_start,
		output image_width, image_height, src_address, dst_address, taps, load_done);
	modport controller (output load_start,
		input image_width, image_height, src_address, dst_address, load_done);
	modport datapath (input taps);

endinterface

`default_nettype wire

// File: source/conv_pkg.sv
`default_nettype none

package conv_pkg;

	typedef logic [7:0] pixel_t;
	typedef logic signed [7:0] coef_t;
	typedef pixel_t [2:0] column_t; // [0] is the top row
	typedef logic [31:0] addr_t;
	typedef logic [15:0] dim_t;

	typedef enum logic [3:0] {
		IDLE,
		LOAD_CONFIG,
		FETCH,
		FETCH_SETTLE,
		FETCH_WAIT,
		PRIME,
		OPERATE,
		DRAIN,
		STORE,
		STORE_SETTLE,
		STORE_WAIT,
		NEXT_BAND,
		DONE
	} ctrl_state_e;

	typedef enum logic [2:0] {
		F_DIMS,
		F_SRC,
		F_DST,
		F_TAPS0,
		F_TAPS1,
		F_TAPS2,
		F_END
	} cfg_field_e;

	// byte offsets from the mapped base
	localparam addr_t cfg_ofs_dims = 32'h000;
	localparam addr_t cfg_ofs_src = 32'h004;
	localparam addr_t cfg_ofs_dst = 32'h008;
	localparam addr_t cfg_ofs_taps0 = 32'h00c;
	localparam addr_t cfg_ofs_taps1 = 32'h010;
	localparam addr_t cfg_ofs_taps2 = 32'h014;
	localparam addr_t cfg_ofs_start = 32'h120;

endpackage

`default_nettype wire
